//--- Makefile
TOP = tb_armController

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

//--- armController.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module armController
  import armCtrlPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] InstrD,
  input  logic [`FLAG_W-1:0]  FlagsE,
  input  logic [`INSTR_W-1:0] ALUResultE,
  input  logic                RegFileRzD,
  // Hazard unit levels
  input  logic                StallE,
  input  logic                FlushE,
  input  logic                StallM,
  input  logic                StallW,
  input  logic                FlushW,
  // Decode
  output logic [1:0]          RegSrcD,
  output logic [1:0]          ImmSrcD,
  output logic                MultSelectD,
  // Execute
  output logic                ALUSrcE,
  output logic [3:0]          ALUControlE,
  output logic [2:0]          MultControlE,
  output logic                MemtoRegE,
  output logic                BranchTakenE,
  output logic                WriteByteE,
  output logic [`FLAG_W-1:0]  PreviousFlagsE,
  // Memory
  output logic                MemWriteM,
  output logic                RegWriteM,
  output logic                MemtoRegM,
  output logic [`LANES-1:0]   ByteMaskM,
  // Writeback
  output logic                RegWriteW,
  output logic                MemtoRegW,
  output logic                PCSrcW,
  output logic                LoadLengthW,
  output logic [1:0]          ByteOffsetW,
  output logic                PCWrPendingF
);

  decCtrlT decCtrl;
  memCtrlT memCtrl;
  logic    pcSrcE;

  ctrlIf cIf ();  // Decode to Execute

  // ==================================================
  // Decode
  // ==================================================
  instrDecoder decoder0 (
    .InstrD     (InstrD),
    .RegFileRzD (RegFileRzD),
    .dec        (cIf.dec),
    .decCtrl    (decCtrl)
  );

  assign RegSrcD     = decCtrl.regSrc;
  assign ImmSrcD     = decCtrl.immSrc;
  assign MultSelectD = decCtrl.multSelect;

  // Execute, condition and flags
  condExecUnit exUnit0 (
    .clk            (clk),
    .rst            (rst),
    .StallE         (StallE),
    .FlushE         (FlushE),
    .ex             (cIf.ex),
    .FlagsE         (FlagsE),
    .ALUResultE     (ALUResultE),
    .ALUSrcE        (ALUSrcE),
    .ALUControlE    (ALUControlE),
    .MultControlE   (MultControlE),
    .MemtoRegE      (MemtoRegE),
    .BranchTakenE   (BranchTakenE),
    .WriteByteE     (WriteByteE),
    .PreviousFlagsE (PreviousFlagsE),
    .PCSrcE         (pcSrcE),
    .memCtrl        (memCtrl)
  );

  // Memory and Writeback
  memWbStages memWb0 (
    .clk          (clk),
    .rst          (rst),
    .StallM       (StallM),
    .StallW       (StallW),
    .FlushW       (FlushW),
    .memCtrl      (memCtrl),
    .pcSrcD       (cIf.pcSrcD),
    .pcSrcE       (pcSrcE),
    .MemWriteM    (MemWriteM),
    .RegWriteM    (RegWriteM),
    .MemtoRegM    (MemtoRegM),
    .ByteMaskM    (ByteMaskM),
    .RegWriteW    (RegWriteW),
    .MemtoRegW    (MemtoRegW),
    .PCSrcW       (PCSrcW),
    .LoadLengthW  (LoadLengthW),
    .ByteOffsetW  (ByteOffsetW),
    .PCWrPendingF (PCWrPendingF)
  );

endmodule

//--- armCtrlPkg.sv
`include "armCtrl_settings.svh"

package armCtrlPkg;

  // ==================================================
  // Decode-stage selects, combinational
  // ==================================================
  typedef struct packed {
    logic [1:0] regSrc;      // Register file read port selects
    logic [1:0] immSrc;      // Immediate extension format
    logic       multSelect;  // Route operands to the multiplier
  } decCtrlT;

  // ==================================================
  // Controls registered into Execute
  // ==================================================
  typedef struct packed {
    logic       aluSrc;       // Immediate as operand B
    logic [3:0] aluControl;   // DP opcode, or add/sub for memory ops
    logic [2:0] multControl;  // Multiply variant, bits 23:21
    logic [1:0] flagWrite;    // Bit 1 NZ, bit 0 CV
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;        // Instruction may redirect the PC
    logic       byteAccess;   // LDRB/STRB
    logic       load;
  } exCtrlT;

  // Condition-gated controls into Memory
  typedef struct packed {
    logic              memWrite;
    logic              regWrite;
    logic              memtoReg;
    logic              pcSrc;
    logic [`LANES-1:0] byteMask;    // Write strobes per byte lane
    logic              loadLength;  // High for byte loads
    logic [1:0]        byteOffset;  // Address bits 1:0
  } memCtrlT;

  // Writeback subset
  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       loadLength;
    logic [1:0] byteOffset;  // Picks the loaded byte
  } wbCtrlT;

endpackage

//--- armCtrl_settings.svh
`ifndef ARMCTRL_SETTINGS_SVH
`define ARMCTRL_SETTINGS_SVH

// ==================================================
// Core-wide widths
// ==================================================

// Instruction word, fetched and decoded as one unit
`define INSTR_W 32

// Condition flags in NZCV order, N in the top bit
`define FLAG_W 4

// Bytes per data word, one write strobe each
`define LANES 4

`endif

//--- armInstrPkg.sv
`include "armCtrl_settings.svh"

package armInstrPkg;

  // ==================================================
  // Instruction encoding
  // ==================================================

  // Raw instruction word as seen in Decode
  typedef logic [`INSTR_W-1:0] instrT;

  // Instruction kinds recognized by the decoder
  typedef enum logic [2:0] {
    undef  = 3'd0,  // Outside the subset, decodes to a bubble
    dpReg  = 3'd1,  // Data processing, register operand 2
    dpImm  = 3'd2,  // Data processing, rotated immediate
    mult   = 3'd3,  // MUL/MLA family, select and opcode only
    ldr    = 3'd4,  // Load word or byte
    str    = 3'd5,  // Store word or byte
    branch = 3'd6,  // B with 24-bit offset
    bx     = 3'd7   // Branch to register
  } instrClassT;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    condEq = 4'h0,  // Z set
    condNe = 4'h1,  // Z clear
    condCs = 4'h2,  // Carry set
    condCc = 4'h3,  // Carry clear
    condMi = 4'h4,  // Negative
    condPl = 4'h5,  // Positive or zero
    condVs = 4'h6,  // Overflow
    condVc = 4'h7,  // No overflow
    condHi = 4'h8,  // Unsigned higher
    condLs = 4'h9,  // Unsigned lower or same
    condGe = 4'hA,  // Signed greater or equal
    condLt = 4'hB,  // Signed less than
    condGt = 4'hC,  // Signed greater than
    condLe = 4'hD,  // Signed less or equal
    condAl = 4'hE   // Always
  } condT;

endpackage

//--- condExecUnit.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module condExecUnit
  import armInstrPkg::*;
  import armCtrlPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                StallE,
  input  logic                FlushE,
  ctrlIf.ex                   ex,
  input  logic [`FLAG_W-1:0]  FlagsE,      // NZCV produced by the ALU
  input  logic [`INSTR_W-1:0] ALUResultE,  // Address for memory ops
  output logic                ALUSrcE,
  output logic [3:0]          ALUControlE,
  output logic [2:0]          MultControlE,
  output logic                MemtoRegE,
  output logic                BranchTakenE,
  output logic                WriteByteE,
  output logic [`FLAG_W-1:0]  PreviousFlagsE,
  output logic                PCSrcE,      // Ungated, for the pending hint
  output memCtrlT             memCtrl
);

  exCtrlT             exQ;
  condT               condE;
  logic [`FLAG_W-1:0] flagsQ;
  logic [`FLAG_W-1:0] flagsNext;
  logic               n, z, c, v;
  logic               condPass;
  logic [`LANES-1:0]  byteMaskE;

  // ==================================================
  // Execute stage registers
  // ==================================================
  stageReg #(.payloadT(exCtrlT)) exReg (
    .clk (clk),
    .rst (rst),
    .en  (~StallE),
    .clr (FlushE),
    .d   (ex.exCtrl),
    .q   (exQ)
  );

  stageReg #(.payloadT(condT)) condReg (
    .clk (clk),
    .rst (rst),
    .en  (~StallE),
    .clr (FlushE),
    .d   (ex.cond),
    .q   (condE)
  );

  // ==================================================
  // Condition check against stored flags
  // ==================================================
  assign {n, z, c, v} = flagsQ;

  always_comb begin
    case (condE)
      condEq:  condPass = z;
      condNe:  condPass = ~z;
      condCs:  condPass = c;
      condCc:  condPass = ~c;
      condMi:  condPass = n;
      condPl:  condPass = ~n;
      condVs:  condPass = v;
      condVc:  condPass = ~v;
      condHi:  condPass = c & ~z;
      condLs:  condPass = ~c | z;
      condGe:  condPass = (n == v);
      condLt:  condPass = (n != v);
      condGt:  condPass = ~z & (n == v);
      condLe:  condPass = z | (n != v);
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;  // NV never executes
    endcase
  end

  // NZ and CV update independently
  always_comb begin
    flagsNext = flagsQ;
    if (condPass && exQ.flagWrite[1])
      flagsNext[3:2] = FlagsE[3:2];
    if (condPass && exQ.flagWrite[0])
      flagsNext[1:0] = FlagsE[1:0];
  end

  always_ff @(posedge clk) begin
    if (rst)
      flagsQ <= '0;
    else if (!StallE)
      flagsQ <= flagsNext;
  end

  // Byte access strobes one lane, word access all of them
  always_comb begin
    for (int i = 0; i < `LANES; i++)
      byteMaskE[i] = ~exQ.byteAccess | (ALUResultE[1:0] == i);
  end

  // ==================================================
  // Outputs and gating
  // ==================================================
  assign ALUSrcE        = exQ.aluSrc;
  assign ALUControlE    = exQ.aluControl;
  assign MultControlE   = exQ.multControl;
  assign MemtoRegE      = exQ.memtoReg;
  assign PreviousFlagsE = flagsQ;
  assign PCSrcE         = exQ.pcSrc;
  assign BranchTakenE   = exQ.branch & condPass;
  assign WriteByteE     = exQ.byteAccess & exQ.memWrite;  // STRB in flight

  assign memCtrl.memWrite   = exQ.memWrite & condPass;
  assign memCtrl.regWrite   = exQ.regWrite & condPass;
  assign memCtrl.memtoReg   = exQ.memtoReg;
  assign memCtrl.pcSrc      = exQ.pcSrc & condPass;
  assign memCtrl.byteMask   = byteMaskE;
  assign memCtrl.loadLength = exQ.byteAccess & exQ.load;  // LDRB only
  assign memCtrl.byteOffset = ALUResultE[1:0];

  // A flushed Execute stage leaves nothing to gate into Memory
  bubbleNoWrite: assert property (@(posedge clk) disable iff (rst)
    (FlushE && !StallE) |=>
      !(memCtrl.memWrite || memCtrl.regWrite || memCtrl.pcSrc || BranchTakenE));

endmodule

//--- ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf
  import armInstrPkg::*, armCtrlPkg::*;
();

  // ==================================================
  // Decode to Execute bundle
  // ==================================================
  exCtrlT exCtrl;  // Controls waiting for the Execute register
  condT   cond;    // Condition field of the Decode instruction
  logic   pcSrcD;  // Decode instruction may write the PC

  // Decoder drives the bundle
  modport dec (
    output exCtrl,
    output cond,
    output pcSrcD
  );

  // Execute side samples it
  modport ex (
    input exCtrl,
    input cond,
    input pcSrcD
  );

endinterface

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
  import armInstrPkg::*;
  import armCtrlPkg::*;
(
  input  instrT   InstrD,
  input  logic    RegFileRzD,  // Destination aliases zero, no PC write
  ctrlIf.dec      dec,
  output decCtrlT decCtrl
);

  instrClassT cls;
  logic       isLdSt;
  logic       isDp;
  logic       testOp;  // TST/TEQ/CMP/CMN only touch flags
  exCtrlT     ctrl;

  // ==================================================
  // Classify
  // ==================================================
  always_comb begin
    cls = undef;
    case (InstrD[27:25])
      3'b000: begin
        if (InstrD[7:4] == 4'b1001)
          cls = mult;
        else if (InstrD[27:4] == 24'h12_FFF1)  // BX Rm pattern
          cls = bx;
        else
          cls = dpReg;
      end
      3'b001:         cls = dpImm;
      3'b010, 3'b011: cls = InstrD[20] ? ldr : str;  // L bit
      3'b101:         cls = branch;
      default:        cls = undef;  // LDM/STM, coprocessor, SWI
    endcase
  end

  assign isLdSt = (cls == ldr) || (cls == str);
  assign isDp   = (cls == dpReg) || (cls == dpImm) || (cls == mult);
  assign testOp = (InstrD[24:23] == 2'b10);

  // ==================================================
  // Control word
  // ==================================================
  always_comb begin
    ctrl    = '0;
    decCtrl = '0;
    case (cls)
      dpReg: ctrl.regWrite = ~testOp;
      dpImm: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = ~testOp;
      end
      mult: begin
        ctrl.regWrite      = 1'b1;
        ctrl.multControl   = InstrD[23:21];
        decCtrl.multSelect = 1'b1;
      end
      ldr, str: begin
        decCtrl.immSrc = InstrD[25] ? 2'b00 : 2'b01;  // I bit clear means imm12
        ctrl.aluSrc    = ~InstrD[25];
        ctrl.load      = (cls == ldr);
        ctrl.memtoReg  = (cls == ldr);
        ctrl.regWrite  = (cls == ldr);
        ctrl.memWrite  = (cls == str);
        if (cls == str)
          decCtrl.regSrc = 2'b10;  // Read Rd as store data
      end
      branch: begin
        decCtrl.regSrc = 2'b01;  // PC as operand A
        decCtrl.immSrc = 2'b10;  // imm24, shifted by two
        ctrl.aluSrc    = 1'b1;
        ctrl.branch    = 1'b1;
      end
      bx: begin
        decCtrl.regSrc = 2'b01;
        ctrl.branch    = 1'b1;  // Target comes from Rm
      end
      default: ;
    endcase

    // ALU operation
    if (isDp) begin
      ctrl.aluControl = InstrD[24:21];
      ctrl.flagWrite  = {2{InstrD[20]}};  // S bit sets all four flags
    end else if (isLdSt)
      ctrl.aluControl = InstrD[23] ? 4'b0100 : 4'b0010;  // U bit picks add or sub
    else if (cls != undef)
      ctrl.aluControl = 4'b0100;

    ctrl.byteAccess = isLdSt & InstrD[22];
    ctrl.pcSrc      = ((InstrD[15:12] == 4'hF) & ctrl.regWrite & ~RegFileRzD)
                    | ctrl.branch;
  end

  assign dec.exCtrl = ctrl;
  assign dec.cond   = condT'(InstrD[31:28]);
  assign dec.pcSrcD = ctrl.pcSrc;

endmodule

//--- memWbStages.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module memWbStages
  import armCtrlPkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              StallM,
  input  logic              StallW,
  input  logic              FlushW,
  input  memCtrlT           memCtrl,
  input  logic              pcSrcD,
  input  logic              pcSrcE,
  output logic              MemWriteM,
  output logic              RegWriteM,
  output logic              MemtoRegM,
  output logic [`LANES-1:0] ByteMaskM,
  output logic              RegWriteW,
  output logic              MemtoRegW,
  output logic              PCSrcW,
  output logic              LoadLengthW,
  output logic [1:0]        ByteOffsetW,
  output logic              PCWrPendingF
);

  memCtrlT memQ;
  wbCtrlT  wbD;
  wbCtrlT  wbQ;

  // ==================================================
  // Memory stage, stall only
  // ==================================================
  stageReg #(.payloadT(memCtrlT)) memReg (
    .clk (clk),
    .rst (rst),
    .en  (~StallM),
    .clr (1'b0),
    .d   (memCtrl),
    .q   (memQ)
  );

  assign MemWriteM = memQ.memWrite;
  assign RegWriteM = memQ.regWrite;
  assign MemtoRegM = memQ.memtoReg;
  assign ByteMaskM = memQ.byteMask;

  // Writeback keeps the register-side subset
  assign wbD = '{regWrite:   memQ.regWrite,
                 memtoReg:   memQ.memtoReg,
                 pcSrc:      memQ.pcSrc,
                 loadLength: memQ.loadLength,
                 byteOffset: memQ.byteOffset};

  stageReg #(.payloadT(wbCtrlT)) wbReg (
    .clk (clk),
    .rst (rst),
    .en  (~StallW),
    .clr (FlushW),
    .d   (wbD),
    .q   (wbQ)
  );

  assign RegWriteW   = wbQ.regWrite;
  assign MemtoRegW   = wbQ.memtoReg;
  assign PCSrcW      = wbQ.pcSrc;
  assign LoadLengthW = wbQ.loadLength;
  assign ByteOffsetW = wbQ.byteOffset;

  // Any PC writer still ahead of Writeback holds off fetch
  assign PCWrPendingF = pcSrcD | pcSrcE | memQ.pcSrc;

  // Stores never select memory data for the register file
  noStoreLoad: assert property (@(posedge clk) disable iff (rst)
    !(MemWriteM && MemtoRegM));

endmodule

//--- stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,   // Stage advances, low under stall
  input  logic    clr,  // Load a bubble instead of d
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (rst)
      q <= payloadT'(0);
    else if (en) begin
      if (clr)
        q <= payloadT'(0);  // Bubble, all controls inactive
      else
        q <= d;
    end
  end

  // Once out of reset the stage never holds X controls
  qKnown: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(q));

endmodule

//--- tb.f
+incdir+.
armInstrPkg.sv
armCtrlPkg.sv
stageReg.sv
ctrlIf.sv
instrDecoder.sv
condExecUnit.sv
memWbStages.sv
armController.sv
tb_armController.sv

//--- tb_armController.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module tb_armController
  import armInstrPkg::*;
  import armCtrlPkg::*;
();

  localparam int clkPeriod   = 4;
  localparam int resetCycles = 4;
  localparam int numCycles   = 3000;

  logic                clk, rst;
  logic [`INSTR_W-1:0] InstrD, ALUResultE;
  logic [`FLAG_W-1:0]  FlagsE, PreviousFlagsE;
  logic                RegFileRzD, StallE, FlushE, StallM, StallW, FlushW;
  logic [1:0]          RegSrcD, ImmSrcD, ByteOffsetW;
  logic                MultSelectD, ALUSrcE, MemtoRegE, BranchTakenE, WriteByteE;
  logic [3:0]          ALUControlE;
  logic [2:0]          MultControlE;
  logic                MemWriteM, RegWriteM, MemtoRegM;
  logic [`LANES-1:0]   ByteMaskM;
  logic                RegWriteW, MemtoRegW, PCSrcW, LoadLengthW, PCWrPendingF;

  // Software pipeline, mirrors the DUT stages
  exCtrlT             exM    = '0;
  logic [3:0]         condM  = 4'h0;
  logic [`FLAG_W-1:0] flagsM = '0;
  memCtrlT            memM   = '0;
  wbCtrlT             wbM    = '0;

  int          errCount   = 0;
  int          checkCount = 0;
  logic [31:0] lcgState   = 32'h106a_7b03;

  armController dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ==================================================
  // Stimulus sources
  // ==================================================
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    return lcgState;
  endfunction

  // Random word forced into one of the supported shapes
  function automatic logic [31:0] makeInstr();
    logic [31:0] w;
    logic [31:0] r;
    w = nextRand();
    r = nextRand();
    case (r[31:29])
      3'd0:       w[27:25] = 3'b000;                         // DP register
      3'd1:       w[27:25] = 3'b001;                         // DP immediate
      3'd2:       {w[27:25], w[7:4]} = {3'b000, 4'b1001};    // Multiply
      3'd3, 3'd4: w[27:26] = 2'b01;                          // LDR/STR
      3'd5:       w[27:25] = 3'b101;                         // B
      3'd6:       w[27:4]  = 24'h12_FFF1;                    // BX
      default:    w[27:25] = 3'b100;                         // LDM, decodes to nothing
    endcase
    if (r[28:27] == 2'b00 && r[31:29] != 3'd6)
      w[15:12] = 4'hF;  // Extra R15 writes
    if (w[31:28] == 4'hF)
      w[31:28] = 4'hE;  // NV is not in the subset
    return w;
  endfunction

  task automatic driveCycle();
    logic [31:0] r;
    r          = nextRand();
    InstrD     = makeInstr();
    ALUResultE = nextRand();
    FlagsE     = r[3:0];
    StallE     = (r[31:29] == 3'd0);  // Each level about one cycle in eight
    FlushE     = (r[28:26] == 3'd0);
    StallM     = (r[25:23] == 3'd0);
    StallW     = (r[22:20] == 3'd0);
    FlushW     = (r[19:17] == 3'd0);
    RegFileRzD = (r[16:15] == 2'd0);
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  function automatic exCtrlT refEx(input logic [31:0] w, input logic rz);
    exCtrlT e;
    logic   isTest;
    e      = '0;
    isTest = (w[24:23] == 2'b10);  // TST TEQ CMP CMN
    if (w[27:25] == 3'b000 && w[7:4] == 4'b1001) begin
      e.regWrite    = 1'b1;
      e.multControl = w[23:21];
      e.aluControl  = w[24:21];
      e.flagWrite   = {w[20], w[20]};
    end else if (w[27:4] == 24'h12_FFF1) begin
      e.branch     = 1'b1;
      e.aluControl = 4'b0100;
    end else if (w[27:26] == 2'b00) begin  // DP, I bit picks immediate
      e.aluSrc     = w[25];
      e.regWrite   = ~isTest;
      e.aluControl = w[24:21];
      e.flagWrite  = {w[20], w[20]};
    end else if (w[27:26] == 2'b01) begin
      e.load       = w[20];
      e.memtoReg   = w[20];
      e.regWrite   = w[20];
      e.memWrite   = ~w[20];
      e.aluSrc     = ~w[25];
      e.aluControl = w[23] ? 4'b0100 : 4'b0010;  // Up adds, down subtracts
      e.byteAccess = w[22];
    end else if (w[27:25] == 3'b101) begin
      e.aluSrc     = 1'b1;
      e.branch     = 1'b1;
      e.aluControl = 4'b0100;
    end
    e.pcSrc = e.branch | (e.regWrite & (w[15:12] == 4'hF) & ~rz);
    return e;
  endfunction

  // Decode-stage selects from the instruction fields
  function automatic decCtrlT refDec(input logic [31:0] w);
    decCtrlT d;
    d = '0;
    if (w[27:25] == 3'b000 && w[7:4] == 4'b1001)
      d.multSelect = 1'b1;
    else if (w[27:4] == 24'h12_FFF1)
      d.regSrc = 2'b01;
    else if (w[27:26] == 2'b01) begin
      d.immSrc = w[25] ? 2'b00 : 2'b01;  // imm12 unless register offset
      d.regSrc = w[20] ? 2'b00 : 2'b10;  // Stores read Rd
    end else if (w[27:25] == 3'b101) begin
      d.regSrc = 2'b01;  // PC base
      d.immSrc = 2'b10;  // imm24
    end
    return d;
  endfunction

  function automatic logic condHolds(input logic [3:0] cnd, input logic [3:0] f);
    logic n, z, c, v;
    {n, z, c, v} = f;
    case (cnd)
      4'h0: return z;
      4'h1: return ~z;
      4'h2: return c;
      4'h3: return ~c;
      4'h4: return n;
      4'h5: return ~n;
      4'h6: return v;
      4'h7: return ~v;
      4'h8: return c & ~z;
      4'h9: return ~c | z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return ~z & (n == v);
      4'hD: return z | (n != v);
      4'hE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic checkDec(input decCtrlT got, input decCtrlT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: Decode selects got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic checkEx(input exCtrlT got, input exCtrlT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: Execute controls got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic checkMem(input memCtrlT got, input memCtrlT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: Memory controls got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic checkWb(input wbCtrlT got, input wbCtrlT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: Writeback controls got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic checkFlags(input logic [`FLAG_W-1:0] got, input logic [`FLAG_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: Stored flags got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic checkPending(input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[FAIL] %0t: PCWrPendingF got %b expected %b", $time, got, exp);
    end
  endtask

  // Checks late in the cycle, then steps the model to the next edge
  initial begin : compareProc
    exCtrlT             obsEx, expEx, nextEx;
    memCtrlT            obsMem, expMem, gated;
    wbCtrlT             obsWb;
    decCtrlT            obsDec;
    logic               pass;
    logic [`FLAG_W-1:0] nextFlags;
    forever begin
      @(posedge clk);
      #3;
      pass = condHolds(condM, flagsM);
      obsEx = '0;  // Only fields visible at the top level
      {obsEx.aluSrc, obsEx.aluControl, obsEx.multControl} = {ALUSrcE, ALUControlE, MultControlE};
      {obsEx.memtoReg, obsEx.branch, obsEx.byteAccess} = {MemtoRegE, BranchTakenE, WriteByteE};
      expEx = '0;
      {expEx.aluSrc, expEx.aluControl, expEx.multControl} =
        {exM.aluSrc, exM.aluControl, exM.multControl};
      expEx.memtoReg   = exM.memtoReg;
      expEx.branch     = exM.branch & pass;
      expEx.byteAccess = exM.byteAccess & exM.memWrite;  // STRB only
      checkEx(obsEx, expEx);
      checkFlags(PreviousFlagsE, flagsM);
      obsMem = '0;
      {obsMem.memWrite, obsMem.regWrite, obsMem.memtoReg} = {MemWriteM, RegWriteM, MemtoRegM};
      obsMem.byteMask = ByteMaskM;
      expMem = '0;
      {expMem.memWrite, expMem.regWrite, expMem.memtoReg} =
        {memM.memWrite, memM.regWrite, memM.memtoReg};
      expMem.byteMask = memM.byteMask;
      checkMem(obsMem, expMem);
      obsWb = '{regWrite: RegWriteW, memtoReg: MemtoRegW, pcSrc: PCSrcW,
                loadLength: LoadLengthW, byteOffset: ByteOffsetW};
      checkWb(obsWb, wbM);
      obsDec = '{regSrc: RegSrcD, immSrc: ImmSrcD, multSelect: MultSelectD};
      checkDec(obsDec, refDec(InstrD));
      nextEx = refEx(InstrD, RegFileRzD);
      checkPending(PCWrPendingF, nextEx.pcSrc | exM.pcSrc | memM.pcSrc);

      // Condition-gated bundle for Memory
      gated            = '0;
      gated.memWrite   = exM.memWrite & pass;
      gated.regWrite   = exM.regWrite & pass;
      gated.memtoReg   = exM.memtoReg;
      gated.pcSrc      = exM.pcSrc & pass;
      gated.byteMask   = exM.byteAccess ? (4'b0001 << ALUResultE[1:0]) : 4'b1111;
      gated.loadLength = exM.byteAccess & exM.load;  // Byte loads
      gated.byteOffset = ALUResultE[1:0];
      nextFlags = flagsM;
      if (pass && exM.flagWrite[1])
        nextFlags[3:2] = FlagsE[3:2];  // NZ
      if (pass && exM.flagWrite[0])
        nextFlags[1:0] = FlagsE[1:0];  // CV

      if (rst) begin
        {exM, condM, flagsM, memM, wbM} = '0;
      end else begin
        if (!StallW)  // Uses Memory contents before the step
          wbM = FlushW ? '0 : '{regWrite: memM.regWrite, memtoReg: memM.memtoReg,
                                pcSrc: memM.pcSrc, loadLength: memM.loadLength,
                                byteOffset: memM.byteOffset};
        if (!StallM)
          memM = gated;
        if (!StallE) begin
          exM    = FlushE ? '0 : nextEx;
          condM  = FlushE ? 4'h0 : InstrD[31:28];
          flagsM = nextFlags;  // Flush does not block the flag write
        end
      end
    end
  end

  // ==================================================
  // Run control
  // ==================================================
  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst        = 1'b1;
    InstrD     = '0;  // Decodes to no PC write while in reset
    ALUResultE = '0;
    FlagsE     = '0;
    RegFileRzD = 1'b0;
    {StallE, FlushE, StallM, StallW, FlushW} = '0;
    repeat (resetCycles) @(posedge clk);
    for (int i = 0; i < numCycles; i++) begin
      #1;
      rst = 1'b0;
      driveCycle();
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Drain, last check lands before this edge
    $display("Checks: %0d  Errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial begin : watchdog
    #(clkPeriod * (resetCycles + numCycles + 20));
    $display("Timeout: the run did not reach its end in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
